/* hdl/mdu_iq_defs.svh */
`ifndef MDU_IQ_DEFS_SVH
`define MDU_IQ_DEFS_SVH

// issue queue geometry
`define MDU_QUEUE_LEN 8
`define MDU_QUEUE_IDX_LEN 4   // holds 0..8

// physical register file tag
`define PRF_TAG_W 6

// APB register block
`define CSR_ADDR_W 4

`endif

/* hdl/mdu_uop_pkg.sv */
`include "mdu_iq_defs.svh"

package mdu_uop_pkg;

    typedef logic [`PRF_TAG_W-1:0] prf_num_t;

    // decoded multiply/divide micro-op
    typedef struct packed {
        logic       valid;
        logic       is_mul;     // clear for a divide
        logic [2:0] func;       // signedness, high half or remainder
        prf_num_t   prs0;
        prf_num_t   prs1;
        prf_num_t   prd;
        logic [5:0] rob_idx;
    } mdu_uop_t;

    // operand readiness as seen by the arbiter
    typedef struct packed {
        logic prs0_rdy;
        logic prs1_rdy;
    } arb_info_t;

    // one queue slot
    typedef struct packed {
        mdu_uop_t  uop;
        arb_info_t rdys;
    } mdu_iq_meta_t;

endpackage

/* hdl/mdu_iq_ctrl_pkg.sv */
`include "mdu_iq_defs.svh"

package mdu_iq_ctrl_pkg;

    // per-slot steering from the queue
    typedef struct packed {
        logic enq_en;   // write the incoming op
        logic cmp_en;   // take the word from the slot above
        logic freeze;   // queue full, enqueue ignored
    } queue_ctrl_t;

    // APB register map
    localparam logic [`CSR_ADDR_W-1:0] CSR_CTRL    = 'h0;
    localparam logic [`CSR_ADDR_W-1:0] CSR_STATUS  = 'h4;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MUL_CNT = 'h8;
    localparam logic [`CSR_ADDR_W-1:0] CSR_DIV_CNT = 'hC;

    // CTRL fields
    localparam int CTRL_ISSUE_EN_BIT = 0;
    localparam int CTRL_FLUSH_BIT    = 1;   // write-only, self-clearing

endpackage

/* hdl/iq_sel_if.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

interface iq_sel_if (
    input logic clk
);
    logic [`MDU_QUEUE_LEN-1:0]     ready_vec;
    logic [`MDU_QUEUE_LEN-1:0]     valid_vec;
    logic [`MDU_QUEUE_LEN-1:0]     is_mul_vec;
    logic [`MDU_QUEUE_IDX_LEN-2:0] sel_idx;     // entry leaves at next edge
    logic                          sel_valid;

    modport queue (
        output ready_vec, valid_vec, is_mul_vec,
        input  sel_idx, sel_valid
    );

    modport select (
        input  clk,
        input  ready_vec, valid_vec, is_mul_vec,
        output sel_idx, sel_valid
    );
endinterface

/* hdl/iq_entry_mdu.sv */
`timescale 1ns/1ps

module iq_entry_mdu
    import mdu_uop_pkg::*, mdu_iq_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    input  queue_ctrl_t  ctrl,
    input  mdu_iq_meta_t enq_data,
    input  mdu_iq_meta_t up_data,
    input  arb_info_t    up_rdy,      // refreshed readiness of the slot above
    input  logic         busy_rs0,
    input  logic         busy_rs1,
    output mdu_iq_meta_t dout,
    output prf_num_t     rs0,
    output prf_num_t     rs1,
    output logic         rdy,
    output arb_info_t    rdy_next,
    output logic         is_mul
);
    logic         take_enq;
    mdu_iq_meta_t next_data;

    assign take_enq = ctrl.enq_en && !ctrl.freeze;

    // wakeup is sticky once seen
    assign rdy_next.prs0_rdy = dout.rdys.prs0_rdy || !busy_rs0;
    assign rdy_next.prs1_rdy = dout.rdys.prs1_rdy || !busy_rs1;

    always_comb begin
        if (take_enq) begin
            next_data = enq_data;   // readiness already folded in by the queue
        end else if (ctrl.cmp_en) begin
            next_data      = up_data;
            next_data.rdys = up_rdy;
        end else begin
            next_data      = dout;
            next_data.rdys = rdy_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            dout <= '0;
        end else begin
            dout <= next_data;
        end
    end

    assign rs0    = dout.uop.prs0;
    assign rs1    = dout.uop.prs1;
    assign rdy    = dout.rdys.prs0_rdy && dout.rdys.prs1_rdy;
    assign is_mul = dout.uop.is_mul;

endmodule

/* hdl/iq_mdu.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

module iq_mdu
    import mdu_uop_pkg::*, mdu_iq_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          enq_req,
    input  mdu_uop_t                      enq_data,
    iq_sel_if.queue                       deq,
    input  logic [`MDU_QUEUE_LEN:0]       busy_l,
    input  logic [`MDU_QUEUE_LEN:0]       busy_r,
    output logic                          full,
    output logic [`MDU_QUEUE_IDX_LEN-1:0] count,
    output mdu_iq_meta_t                  issue_data,
    output prf_num_t [`MDU_QUEUE_LEN:0]   sb_tag_l,
    output prf_num_t [`MDU_QUEUE_LEN:0]   sb_tag_r
);
    localparam int N     = `MDU_QUEUE_LEN;
    localparam int IDX_W = `MDU_QUEUE_IDX_LEN;
    localparam int SEL_W = `MDU_QUEUE_IDX_LEN - 1;

    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] deq_amt;
    logic [IDX_W-1:0] enq_amt;
    logic [IDX_W-1:0] wr_pos;
    logic [N-1:0]     wr_vec;
    logic [N-1:0]     ready_vec;
    logic [N-1:0]     valid_vec;
    logic [N-1:0]     is_mul_vec;
    mdu_iq_meta_t     enq_meta;
    mdu_iq_meta_t     slot_data [N+1];
    arb_info_t        slot_rdy  [N+1];
    queue_ctrl_t      slot_ctrl [N];

    assign full    = (tail == IDX_W'(N));
    assign count   = tail;
    assign deq_amt = IDX_W'(deq.sel_valid);
    assign enq_amt = IDX_W'(enq_req);
    assign wr_pos  = tail - deq_amt;   // one lower when an issue collapses the queue
    assign wr_vec  = enq_req ? (N'(1) << wr_pos) : '0;

    // index N of the scoreboard ports looks up the incoming op
    assign sb_tag_l[N] = enq_data.prs0;
    assign sb_tag_r[N] = enq_data.prs1;

    always_comb begin
        enq_meta.uop           = enq_data;
        enq_meta.rdys.prs0_rdy = !busy_l[N];
        enq_meta.rdys.prs1_rdy = !busy_r[N];
    end

    assign slot_data[N] = '0;   // nothing shifts in above the top slot
    assign slot_rdy[N]  = '0;

    for (genvar i = 0; i < N; i++) begin : g_slot
        assign slot_ctrl[i].enq_en = wr_vec[i];
        assign slot_ctrl[i].cmp_en = deq.sel_valid && (SEL_W'(i) >= deq.sel_idx);
        assign slot_ctrl[i].freeze = full;
        assign valid_vec[i]        = (IDX_W'(i) < tail);

        iq_entry_mdu u_iq_entry_mdu (
            .clk      (clk),
            .rst_n    (rst_n),
            .flush    (flush),
            .ctrl     (slot_ctrl[i]),
            .enq_data (enq_meta),
            .up_data  (slot_data[i+1]),
            .up_rdy   (slot_rdy[i+1]),
            .busy_rs0 (busy_l[i]),
            .busy_rs1 (busy_r[i]),
            .dout     (slot_data[i]),
            .rs0      (sb_tag_l[i]),
            .rs1      (sb_tag_r[i]),
            .rdy      (ready_vec[i]),
            .rdy_next (slot_rdy[i]),
            .is_mul   (is_mul_vec[i])
        );
    end

    assign deq.ready_vec  = ready_vec;
    assign deq.valid_vec  = valid_vec;
    assign deq.is_mul_vec = is_mul_vec;
    assign issue_data     = slot_data[deq.sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail <= '0;
        end else if (full) begin
            tail <= tail - deq_amt;   // frozen, only issue moves the tail
        end else begin
            tail <= tail + enq_amt - deq_amt;
        end
    end

    a_tail_bound: assert property (@(posedge clk) disable iff (!rst_n)
        tail <= IDX_W'(N));

    // when full the top slot holds or clears and never takes the incoming op
    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
        (full && enq_req && !flush) |=> slot_data[N-1].uop
            == ($past(deq.sel_valid) ? mdu_uop_t'('0) : $past(slot_data[N-1].uop)));

endmodule

/* hdl/mdu_issue_select.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

module mdu_issue_select (
    iq_sel_if.select sel,
    input  logic     issue_en,
    input  logic     mul_busy,
    input  logic     div_busy
);
    localparam int N     = `MDU_QUEUE_LEN;
    localparam int SEL_W = `MDU_QUEUE_IDX_LEN - 1;

    logic [N-1:0] unit_free;
    logic [N-1:0] eligible;

    // multiplies wait on mul_busy, divides on div_busy
    assign unit_free = ~((sel.is_mul_vec & {N{mul_busy}}) | (~sel.is_mul_vec & {N{div_busy}}));
    assign eligible  = sel.valid_vec & sel.ready_vec & unit_free & {N{issue_en}};

    // slot 0 is oldest, lowest hit wins
    always_comb begin
        sel.sel_idx   = '0;
        sel.sel_valid = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                sel.sel_idx   = SEL_W'(i);
                sel.sel_valid = 1'b1;
            end
        end
    end

    // picked slot is eligible and nothing older is
    a_sel_eligible: assert property (@(posedge sel.clk)
        sel.sel_valid |-> eligible[sel.sel_idx]
            && (eligible & ((N'(1) << sel.sel_idx) - N'(1))) == '0);

endmodule

/* hdl/mdu_iq_csr.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

module mdu_iq_csr
    import mdu_iq_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`CSR_ADDR_W-1:0]        paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic [`MDU_QUEUE_IDX_LEN-1:0] count,
    input  logic                          issue_fire,
    input  logic                          issue_is_mul,
    output logic                          issue_en,
    output logic                          flush_req
);
    localparam int IDX_W = `MDU_QUEUE_IDX_LEN;

    logic        addr_hit;
    logic        wr_en;
    logic        queue_full;
    logic [31:0] rd_mux;
    logic [31:0] mul_cnt;
    logic [31:0] div_cnt;

    assign pready     = 1'b1;   // zero wait states
    assign wr_en      = psel && penable && pwrite;
    assign queue_full = (count == IDX_W'(`MDU_QUEUE_LEN));

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (paddr)
            CSR_CTRL:    rd_mux[CTRL_ISSUE_EN_BIT] = issue_en;   // flush reads as 0
            CSR_STATUS:  rd_mux = {{(31 - IDX_W){1'b0}}, queue_full, count};
            CSR_MUL_CNT: rd_mux = mul_cnt;
            CSR_DIV_CNT: rd_mux = div_cnt;
            default:     addr_hit = 1'b0;
        endcase
    end

    assign prdata    = (psel && !pwrite) ? rd_mux : '0;
    assign pslverr   = psel && penable && !addr_hit;
    assign flush_req = wr_en && (paddr == CSR_CTRL) && pwdata[CTRL_FLUSH_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_en <= 1'b1;
        end else if (wr_en && (paddr == CSR_CTRL)) begin
            issue_en <= pwdata[CTRL_ISSUE_EN_BIT];
        end
    end

    // any write clears, write wins over a same-cycle issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_cnt <= '0;
            div_cnt <= '0;
        end else begin
            if (wr_en && (paddr == CSR_MUL_CNT)) begin
                mul_cnt <= '0;
            end else if (issue_fire && issue_is_mul) begin
                mul_cnt <= mul_cnt + 32'd1;
            end
            if (wr_en && (paddr == CSR_DIV_CNT)) begin
                div_cnt <= '0;
            end else if (issue_fire && !issue_is_mul) begin
                div_cnt <= div_cnt + 32'd1;
            end
        end
    end

    // unmapped write errors in the access phase and leaves CTRL alone
    a_unmapped_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !penable && pwrite && !addr_hit) |=> pslverr ##1 $stable(issue_en));

endmodule

/* hdl/mdu_issue_unit.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

module mdu_issue_unit
    import mdu_uop_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        enq_valid,
    output logic                        enq_ready,
    input  mdu_uop_t                    enq_uop,
    output logic                        issue_valid,
    output mdu_uop_t                    issue_uop,
    input  logic                        mul_busy,
    input  logic                        div_busy,
    output prf_num_t [`MDU_QUEUE_LEN:0] sb_tag_l,
    output prf_num_t [`MDU_QUEUE_LEN:0] sb_tag_r,
    input  logic [`MDU_QUEUE_LEN:0]     busy_l,
    input  logic [`MDU_QUEUE_LEN:0]     busy_r,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`CSR_ADDR_W-1:0]      paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr
);
    logic                          queue_full;
    logic                          queue_flush;
    logic [`MDU_QUEUE_IDX_LEN-1:0] queue_count;
    logic                          issue_en;
    logic                          flush_req;
    mdu_iq_meta_t                  issue_meta;

    iq_sel_if sel_bus (.clk(clk));

    assign queue_flush = flush || flush_req;
    assign enq_ready   = !queue_full;
    assign issue_valid = sel_bus.sel_valid;

    always_comb begin
        issue_uop       = issue_meta.uop;
        issue_uop.valid = sel_bus.sel_valid;
    end

    iq_mdu u_iq_mdu (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (queue_flush),
        .enq_req    (enq_valid),
        .enq_data   (enq_uop),
        .deq        (sel_bus),
        .busy_l     (busy_l),
        .busy_r     (busy_r),
        .full       (queue_full),
        .count      (queue_count),
        .issue_data (issue_meta),
        .sb_tag_l   (sb_tag_l),
        .sb_tag_r   (sb_tag_r)
    );

    mdu_issue_select u_mdu_issue_select (
        .sel      (sel_bus),
        .issue_en (issue_en),
        .mul_busy (mul_busy),
        .div_busy (div_busy)
    );

    mdu_iq_csr u_mdu_iq_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .count        (queue_count),
        .issue_fire   (sel_bus.sel_valid),
        .issue_is_mul (issue_meta.uop.is_mul),
        .issue_en     (issue_en),
        .flush_req    (flush_req)
    );

endmodule

/* verif/tb_mdu_issue_unit.sv */
`timescale 1ns/1ps
`include "mdu_iq_defs.svh"

module tb_mdu_issue_unit
    import mdu_uop_pkg::*;
();
    localparam int    N           = `MDU_QUEUE_LEN;
    localparam int    WAIT_CYCLES = 64;
    localparam string DATA_FILE   = "verif/mdu_issue_testdata.txt";

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    logic                   enq_valid;
    logic                   enq_ready;
    mdu_uop_t               enq_uop;
    logic                   issue_valid;
    mdu_uop_t               issue_uop;
    logic                   mul_busy;
    logic                   div_busy;
    prf_num_t [N:0]         sb_tag_l;
    prf_num_t [N:0]         sb_tag_r;
    logic [N:0]             busy_l;
    logic [N:0]             busy_r;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`CSR_ADDR_W-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    logic     tag_busy [2**`PRF_TAG_W];   // scoreboard model
    mdu_uop_t issued_q [$];
    int       errors;
    int       checks;
    int       tests;
    int       failed_tests;
    int       test_err_base;
    string    test_name;

    mdu_issue_unit u_mdu_issue_unit (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && issue_valid) begin
            issued_q.push_back(issue_uop);   // pre-edge value
        end
        if (rst_n && enq_valid) begin
            check_tag("left tag of the incoming op", sb_tag_l[N], enq_uop.prs0);
            check_tag("right tag of the incoming op", sb_tag_r[N], enq_uop.prs1);
        end
    end

    function automatic mdu_uop_t make_uop(input int is_mul, input int func, input int prs0,
                                          input int prs1, input int prd, input int rob);
        mdu_uop_t u;
        u         = '0;
        u.valid   = 1'b1;
        u.is_mul  = is_mul[0];
        u.func    = func[2:0];
        u.prs0    = prs0[`PRF_TAG_W-1:0];
        u.prs1    = prs1[`PRF_TAG_W-1:0];
        u.prd     = prd[`PRF_TAG_W-1:0];
        u.rob_idx = rob[5:0];
        return u;
    endfunction

    // scoreboard lookup, same-cycle answer
    task automatic answer_scoreboard();
        for (int i = 0; i < N; i++) begin
            busy_l[i] = tag_busy[sb_tag_l[i]];
            busy_r[i] = tag_busy[sb_tag_r[i]];
        end
        busy_l[N] = tag_busy[enq_uop.prs0];   // incoming op, driven in this same step
        busy_r[N] = tag_busy[enq_uop.prs1];
    endtask

    task automatic next_cycle();
        @(negedge clk);
        enq_valid = 1'b0;   // one-shot inputs
        flush     = 1'b0;
        answer_scoreboard();
    endtask

    task automatic check_uop(input string what, input mdu_uop_t got, input mdu_uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input string what, input prf_num_t got, input prf_num_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_issue(input mdu_uop_t exp);
        int waited;
        waited = 0;
        while (issued_q.size() == 0 && waited < WAIT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (issued_q.size() == 0) begin
            errors++;
            $display("no issue came before the deadline of %0d cycles (rob %0d)",
                     WAIT_CYCLES, exp.rob_idx);
        end else begin
            check_uop("issue", issued_q.pop_front(), exp);
        end
    endtask

    task automatic run_quiet(input int n);
        mdu_uop_t u;
        repeat (n) next_cycle();
        while (issued_q.size() != 0) begin
            u = issued_q.pop_front();
            errors++;
            $display("an op issued when none should have (rob %0d)", u.rob_idx);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        next_cycle();
        psel    = 1'b1;   // setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr[`CSR_ADDR_W-1:0];
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!pready && waited < WAIT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        rdata = prdata;
        err   = pslverr;
        if (!pready) begin
            errors++;
            $display("APB transfer to 0x%0h never saw pready", addr);
        end
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        int               fd;
        int               code;
        int               a, b, c, d, e, f;
        logic [31:0]      addr_v;
        logic [31:0]      data_v;
        logic [31:0]      rd_v;
        logic             err_v;
        string            cmd;
        logic [8*160-1:0] line_buf;

        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        enq_valid = 1'b0;
        enq_uop   = '0;
        mul_busy  = 1'b0;
        div_busy  = 1'b0;
        busy_l    = '0;
        busy_r    = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        foreach (tag_busy[i]) tag_busy[i] = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        test_name    = "none";

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        answer_scoreboard();
        check_word("prdata after reset", prdata, 32'h0);

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file %s", DATA_FILE);
        end else begin
            test_err_base = errors;
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    // trailing blank at end of file
                end else if (cmd == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (cmd == "test") begin
                    code = $fscanf(fd, "%s", test_name);
                    test_err_base = errors;
                end else if (cmd == "done") begin
                    tests++;
                    if (errors == test_err_base) begin
                        $display("test %s: ok", test_name);
                    end else begin
                        failed_tests++;
                        $display("test %s: %0d error(s)", test_name, errors - test_err_base);
                    end
                end else if (cmd == "enq" || cmd == "expect_issue") begin
                    code = $fscanf(fd, "%d %d %d %d %d %d", a, b, c, d, e, f);
                    if (cmd == "enq") begin
                        next_cycle();
                        enq_valid = 1'b1;
                        enq_uop   = make_uop(a, b, c, d, e, f);
                        answer_scoreboard();
                    end else begin
                        wait_issue(make_uop(a, b, c, d, e, f));
                    end
                end else if (cmd == "setbusy" || cmd == "unitbusy") begin
                    code = $fscanf(fd, "%d %d", a, b);
                    next_cycle();
                    if (cmd == "setbusy") begin
                        tag_busy[a[`PRF_TAG_W-1:0]] = b[0];
                        answer_scoreboard();
                    end else begin
                        mul_busy = a[0];
                        div_busy = b[0];
                    end
                end else if (cmd == "freeall") begin
                    next_cycle();
                    foreach (tag_busy[i]) tag_busy[i] = 1'b0;
                    answer_scoreboard();
                end else if (cmd == "idle" || cmd == "noissue") begin
                    code = $fscanf(fd, "%d", a);
                    if (cmd == "idle") begin
                        repeat (a) next_cycle();
                    end else begin
                        run_quiet(a);
                    end
                end else if (cmd == "ready") begin
                    code = $fscanf(fd, "%d", a);
                    next_cycle();
                    check_bit("enq_ready", enq_ready, a[0]);
                end else if (cmd == "flush") begin
                    next_cycle();
                    flush = 1'b1;
                end else if (cmd == "apb_wr" || cmd == "apb_rd") begin
                    code = $fscanf(fd, "%h %h %d", addr_v, data_v, a);
                    if (cmd == "apb_wr") begin
                        apb_xfer(1'b1, addr_v, data_v, rd_v, err_v);
                    end else begin
                        apb_xfer(1'b0, addr_v, 32'h0, rd_v, err_v);
                        check_word($sformatf("read of 0x%0h", addr_v), rd_v, data_v);
                    end
                    check_bit($sformatf("pslverr at 0x%0h", addr_v), err_v, a[0]);
                end else begin
                    errors++;
                    $display("unknown command %s in the stimulus file", cmd);
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* mdu_issue_unit.f */
+incdir+hdl
hdl/mdu_uop_pkg.sv
hdl/mdu_iq_ctrl_pkg.sv
hdl/iq_sel_if.sv
hdl/iq_entry_mdu.sv
hdl/iq_mdu.sv
hdl/mdu_issue_select.sv
hdl/mdu_iq_csr.sv
hdl/mdu_issue_unit.sv
verif/tb_mdu_issue_unit.sv

/* Makefile */
# any of these can be overridden, e.g. make sim LOG=run.log
VERILATOR ?= verilator
TOP       ?= tb_mdu_issue_unit
FILELIST  ?= mdu_issue_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/mdu_issue_testdata.txt */
# enq / expect_issue: is_mul func prs0 prs1 prd rob_idx (decimal)
# apb_wr addr data pslverr / apb_rd addr data pslverr (hex), other args decimal
test reset
ready 1
apb_rd 0 1 0
apb_rd 4 0 0
apb_rd 8 0 0
apb_rd c 0 0
noissue 2
done
test in_order
enq 1 0 1 2 40 1
enq 0 1 3 4 41 2
enq 1 2 5 6 42 3
expect_issue 1 0 1 2 40 1
expect_issue 0 1 3 4 41 2
expect_issue 1 2 5 6 42 3
noissue 3
done
test wakeup
setbusy 20 1
enq 1 0 20 2 43 4
enq 0 0 3 4 44 5
enq 1 1 5 6 45 6
expect_issue 0 0 3 4 44 5
expect_issue 1 1 5 6 45 6
noissue 4
setbusy 20 0
expect_issue 1 0 20 2 43 4
done
test full
setbusy 10 1
setbusy 11 1
enq 1 0 10 1 50 10
enq 0 0 10 1 51 11
enq 1 0 10 1 52 12
enq 0 0 11 1 53 13
enq 1 0 10 1 54 14
enq 0 0 10 1 55 15
enq 1 0 10 1 56 16
enq 0 0 10 1 57 17
ready 0
enq 1 0 1 1 58 18
apb_rd 4 18 0
setbusy 11 0
expect_issue 0 0 11 1 53 13
ready 1
apb_rd 4 7 0
flush
freeall
noissue 3
done
test unit_busy
unitbusy 1 0
enq 1 0 1 2 60 20
enq 1 1 3 4 61 21
enq 0 2 5 6 62 22
expect_issue 0 2 5 6 62 22
noissue 3
unitbusy 0 0
expect_issue 1 0 1 2 60 20
expect_issue 1 1 3 4 61 21
done
test flush
setbusy 30 1
enq 1 0 30 1 0 30
enq 0 0 30 1 1 31
apb_rd 4 2 0
flush
apb_rd 4 0 0
enq 1 0 30 1 2 32
apb_wr 0 3 0
apb_rd 4 0 0
setbusy 30 0
noissue 4
apb_rd 0 1 0
done
test apb
apb_wr 8 0 0
apb_wr c 0 0
apb_wr 0 0 0
enq 1 0 1 2 3 40
enq 0 3 4 5 6 41
enq 1 4 7 8 9 42
noissue 4
apb_rd 4 3 0
apb_rd 0 0 0
apb_wr 0 1 0
expect_issue 1 0 1 2 3 40
expect_issue 0 3 4 5 6 41
expect_issue 1 4 7 8 9 42
apb_rd 8 2 0
apb_rd c 1 0
apb_rd 2 0 1
apb_wr 6 ff 1
apb_rd 0 1 0
done
